//--- hw/dmem_defs.svh
// Data memory access block sizing macros for data path, request buffer and PMA table

`ifndef DMEM_DEFS_SVH
`define DMEM_DEFS_SVH

////////////////////////////////////////////////////////////
// Data path
////////////////////////////////////////////////////////////

// Address and data width, one word
`define DMEM_XLEN 32

////////////////////////////////////////////////////////////
// Storage
////////////////////////////////////////////////////////////

// Request buffer entries
`define DMEM_BUF_DEPTH 2

// Physical memory attribute regions
`define DMEM_PMA_CNT 4

`endif

//--- hw/biu_pkg.sv
// Bus interface unit transfer types for access size, protection and privilege

`default_nettype none

package biu_pkg;

  ////////////////////////////////////////////////////////////
  // Transfer size
  ////////////////////////////////////////////////////////////

  // Byte, halfword or word access
  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HWORD = 2'b01,
    WORD  = 2'b10
  } biu_size_t;

  ////////////////////////////////////////////////////////////
  // Protection
  ////////////////////////////////////////////////////////////

  // One bit per attribute, MSB first
  typedef struct packed {
    logic data;
    logic privileged;
    logic user;
  } biu_prot_t;

  // CPU privilege levels as seen on st_prv_i
  localparam logic [1:0] PRV_U = 2'b00;
  localparam logic [1:0] PRV_M = 2'b11;

endpackage

`default_nettype wire

//--- hw/pma_pkg.sv
// Physical memory attribute types describing one address region

`default_nettype none

package pma_pkg;

  ////////////////////////////////////////////////////////////
  // Region configuration
  ////////////////////////////////////////////////////////////

  // Region size given as log2 of its byte count
  // Base address travels as its own word
  typedef struct packed {
    // Region size, log2 bytes
    logic [4:0] size_log2;
    // Loads allowed
    logic       r;
    // Stores allowed
    logic       w;
    // Region takes part in matching
    logic       valid;
  } pmacfg_t;

  // Region with no access at all
  localparam pmacfg_t PMA_NONE = '{
    size_log2: 5'd0,
    r:         1'b0,
    w:         1'b0,
    valid:     1'b0
  };

endpackage

`default_nettype wire

//--- hw/dmem_req_buf.sv
// Data memory request buffer, a small FIFO capturing CPU requests and their protection

`timescale 1ns/100ps
`default_nettype none

`include "dmem_defs.svh"

module dmem_req_buf
  import biu_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic [1:0]             st_prv_i,
  // CPU side
  input  wire logic                   mem_req_i,
  input  wire logic [`DMEM_XLEN-1:0]  mem_adr_i,
  input  wire biu_size_t              mem_size_i,
  input  wire logic                   mem_we_i,
  input  wire logic [`DMEM_XLEN-1:0]  mem_d_i,
  output logic                        mem_rdy_o,
  // Head of queue towards the checker
  output logic                        buf_valid_o,
  output logic [`DMEM_XLEN-1:0]       buf_adr_o,
  output biu_size_t                   buf_size_o,
  output logic                        buf_we_o,
  output logic [`DMEM_XLEN-1:0]       buf_d_o,
  output biu_prot_t                   buf_prot_o,
  input  wire logic                   buf_ready_i
);

  localparam int DEPTH = `DMEM_BUF_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Entry storage
  logic [`DMEM_XLEN-1:0] adr_q [DEPTH];
  biu_size_t             size_q [DEPTH];
  logic                  we_q [DEPTH];
  logic [`DMEM_XLEN-1:0] d_q [DEPTH];
  biu_prot_t             prot_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic      push;
  logic      pop;
  biu_prot_t cap_prot;

  ////////////////////////////////////////////////////////////
  // Protection at capture
  ////////////////////////////////////////////////////////////

  // Privilege frozen per request when it enters the queue
  assign cap_prot.data       = 1'b1;
  assign cap_prot.user       = (st_prv_i == PRV_U);
  assign cap_prot.privileged = (st_prv_i != PRV_U);

  ////////////////////////////////////////////////////////////
  // FIFO control
  ////////////////////////////////////////////////////////////

  assign mem_rdy_o   = (count != CNT_W'(DEPTH));
  assign buf_valid_o = (count != '0);
  assign push        = mem_req_i & mem_rdy_o;
  assign pop         = buf_valid_o & buf_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // Count moves only when one side is active alone
      if (push & ~pop)
        count <= count + 1'b1;
      else if (pop & ~push)
        count <= count - 1'b1;
    end
  end

  // Payload write at the tail
  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      adr_q[wr_ptr]  <= mem_adr_i;
      size_q[wr_ptr] <= mem_size_i;
      we_q[wr_ptr]   <= mem_we_i;
      d_q[wr_ptr]    <= mem_d_i;
      prot_q[wr_ptr] <= cap_prot;
    end
  end

  // Head entry
  assign buf_adr_o  = adr_q[rd_ptr];
  assign buf_size_o = size_q[rd_ptr];
  assign buf_we_o   = we_q[rd_ptr];
  assign buf_d_o    = d_q[rd_ptr];
  assign buf_prot_o = prot_q[rd_ptr];

endmodule

`default_nettype wire

//--- hw/dmem_access_chk.sv
// Data memory access checker for alignment and PMA permissions, forming byte enables

`timescale 1ns/100ps
`default_nettype none

`include "dmem_defs.svh"

module dmem_access_chk
  import biu_pkg::*;
  import pma_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  // Region table
  input  wire pmacfg_t                pma_cfg_i [`DMEM_PMA_CNT],
  input  wire logic [`DMEM_XLEN-1:0]  pma_adr_i [`DMEM_PMA_CNT],
  // Request in
  input  wire logic                   in_valid_i,
  input  wire logic [`DMEM_XLEN-1:0]  in_adr_i,
  input  wire biu_size_t              in_size_i,
  input  wire logic                   in_we_i,
  input  wire logic [`DMEM_XLEN-1:0]  in_d_i,
  input  wire biu_prot_t              in_prot_i,
  output logic                        in_ready_o,
  // Checked request out
  output logic                        out_valid_o,
  output logic [`DMEM_XLEN-1:0]       out_adr_o,
  output biu_size_t                   out_size_o,
  output logic [3:0]                  out_be_o,
  output logic                        out_we_o,
  output logic [`DMEM_XLEN-1:0]       out_d_o,
  output biu_prot_t                   out_prot_o,
  output logic                        out_misaligned_o,
  output logic                        out_fault_o,
  input  wire logic                   out_ready_i
);

  logic                  misaligned;
  logic                  hit;
  logic                  hit_r;
  logic                  hit_w;
  logic                  fault;
  logic [`DMEM_XLEN-1:0] mask;
  logic [3:0]            be;
  logic [`DMEM_XLEN-1:0] wdata;

  // Stage moves when empty or being drained
  assign in_ready_o = ~out_valid_o | out_ready_i;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Half needs bit 0 clear, word needs bits 1..0 clear
  assign misaligned = ((in_size_i == HWORD) & in_adr_i[0]) |
                      ((in_size_i == WORD) & (in_adr_i[1:0] != 2'b00));

  always_comb
  begin
    hit   = 1'b0;
    hit_r = 1'b0;
    hit_w = 1'b0;
    mask  = '0;
    // Walk downwards so the lowest matching region is kept
    for (int i = `DMEM_PMA_CNT - 1; i >= 0; i--)
    begin
      mask = {`DMEM_XLEN{1'b1}} << pma_cfg_i[i].size_log2;
      if (pma_cfg_i[i].valid && ((in_adr_i & mask) == (pma_adr_i[i] & mask)))
      begin
        hit   = 1'b1;
        hit_r = pma_cfg_i[i].r;
        hit_w = pma_cfg_i[i].w;
      end
    end
  end

  // No region, or region lacks the needed permission
  assign fault = ~hit | (in_we_i ? ~hit_w : ~hit_r);

  ////////////////////////////////////////////////////////////
  // Byte lanes
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (in_size_i)
      BYTE:
      begin
        be    = 4'b0001 << in_adr_i[1:0];
        wdata = {(`DMEM_XLEN/8){in_d_i[7:0]}};
      end
      HWORD:
      begin
        be    = 4'b0011 << {in_adr_i[1], 1'b0};
        wdata = {(`DMEM_XLEN/16){in_d_i[15:0]}};
      end
      default:
      begin
        be    = 4'b1111;
        wdata = in_d_i;
      end
    endcase
  end

  // Stage register
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      out_valid_o <= 1'b0;
    else if (in_ready_o)
      out_valid_o <= in_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (in_ready_o & in_valid_i)
    begin
      out_adr_o        <= in_adr_i;
      out_size_o       <= in_size_i;
      out_be_o         <= be;
      out_we_o         <= in_we_i;
      out_d_o          <= wdata;
      out_prot_o       <= in_prot_i;
      out_misaligned_o <= misaligned;
      // Misaligned wins over access fault
      out_fault_o      <= fault & ~misaligned;
    end
  end

endmodule

`default_nettype wire

//--- hw/dmem_biu_if.sv
// Data memory bus sequencer issuing strobes and returning results to the CPU

`timescale 1ns/100ps
`default_nettype none

`include "dmem_defs.svh"

module dmem_biu_if
  import biu_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  // Checked request
  input  wire logic                   in_valid_i,
  input  wire logic [`DMEM_XLEN-1:0]  in_adr_i,
  input  wire biu_size_t              in_size_i,
  input  wire logic [3:0]             in_be_i,
  input  wire logic                   in_we_i,
  input  wire logic [`DMEM_XLEN-1:0]  in_d_i,
  input  wire biu_prot_t              in_prot_i,
  input  wire logic                   in_misaligned_i,
  input  wire logic                   in_fault_i,
  output logic                        in_ready_o,
  // Bus side
  output logic                        biu_stb_o,
  output logic [`DMEM_XLEN-1:0]       biu_adr_o,
  output biu_size_t                   biu_size_o,
  output logic [3:0]                  biu_be_o,
  output logic                        biu_we_o,
  output biu_prot_t                   biu_prot_o,
  output logic [`DMEM_XLEN-1:0]       biu_d_o,
  input  wire logic                   biu_stb_ack_i,
  input  wire logic                   biu_ack_i,
  input  wire logic                   biu_err_i,
  input  wire logic [`DMEM_XLEN-1:0]  biu_q_i,
  // CPU response
  output logic                        mem_ack_o,
  output logic                        mem_err_o,
  output logic                        mem_misaligned_o,
  output logic [`DMEM_XLEN-1:0]       mem_q_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STROBE,
    ST_WAIT_DATA,
    ST_RESPOND
  } state_t;

  state_t                state;
  logic                  take;
  logic                  flagged;
  logic                  resp_err;
  logic [`DMEM_XLEN-1:0] load_sh;
  logic [`DMEM_XLEN-1:0] load_data;

  // One transfer at a time
  assign in_ready_o = (state == ST_IDLE);
  assign take       = in_valid_i & in_ready_o;
  assign flagged    = in_misaligned_i | in_fault_i;

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      state <= ST_IDLE;
    else
    begin
      case (state)
        ST_IDLE:
          if (take)
            state <= flagged ? ST_RESPOND : ST_STROBE;
        ST_STROBE:
          // Response may arrive with the strobe acknowledge
          if (biu_stb_ack_i)
            state <= (biu_ack_i | biu_err_i) ? ST_RESPOND : ST_WAIT_DATA;
        ST_WAIT_DATA:
          if (biu_ack_i | biu_err_i)
            state <= ST_RESPOND;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Transfer attributes held for the whole strobe
  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      biu_adr_o        <= in_adr_i;
      biu_size_o       <= in_size_i;
      biu_be_o         <= in_be_i;
      biu_we_o         <= in_we_i;
      biu_prot_o       <= in_prot_i;
      biu_d_o          <= in_d_i;
      mem_misaligned_o <= in_misaligned_i;
      resp_err         <= flagged;
    end
    else if ((state == ST_STROBE && biu_stb_ack_i) || state == ST_WAIT_DATA)
    begin
      if (biu_ack_i | biu_err_i)
      begin
        resp_err <= biu_err_i;
        mem_q_o  <= load_data;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Load alignment
  ////////////////////////////////////////////////////////////

  // Addressed bytes moved down to bit 0
  assign load_sh = biu_q_i >> {biu_adr_o[1:0], 3'b000};

  always_comb
  begin
    case (biu_size_o)
      BYTE:    load_data = {{(`DMEM_XLEN-8){1'b0}}, load_sh[7:0]};
      HWORD:   load_data = {{(`DMEM_XLEN-16){1'b0}}, load_sh[15:0]};
      default: load_data = load_sh;
    endcase
  end

  // Outputs straight from state
  assign biu_stb_o = (state == ST_STROBE);
  assign mem_ack_o = (state == ST_RESPOND) & ~resp_err;
  assign mem_err_o = (state == ST_RESPOND) & resp_err;

endmodule

`default_nettype wire

//--- hw/dmem_ctrl.sv
// Data memory access top level joining request buffer, access checker and bus sequencer

`timescale 1ns/100ps
`default_nettype none

`include "dmem_defs.svh"

module dmem_ctrl
  import biu_pkg::*;
  import pma_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic [1:0]             st_prv_i,
  // Region table
  input  wire pmacfg_t                pma_cfg_i [`DMEM_PMA_CNT],
  input  wire logic [`DMEM_XLEN-1:0]  pma_adr_i [`DMEM_PMA_CNT],
  // CPU side
  input  wire logic                   mem_req_i,
  input  wire logic [`DMEM_XLEN-1:0]  mem_adr_i,
  input  wire biu_size_t              mem_size_i,
  input  wire logic                   mem_we_i,
  input  wire logic [`DMEM_XLEN-1:0]  mem_d_i,
  output logic                        mem_rdy_o,
  output logic                        mem_ack_o,
  output logic                        mem_err_o,
  output logic                        mem_misaligned_o,
  output logic [`DMEM_XLEN-1:0]       mem_q_o,
  // Bus side
  output logic                        biu_stb_o,
  output logic [`DMEM_XLEN-1:0]       biu_adr_o,
  output biu_size_t                   biu_size_o,
  output logic [3:0]                  biu_be_o,
  output logic                        biu_we_o,
  output biu_prot_t                   biu_prot_o,
  output logic [`DMEM_XLEN-1:0]       biu_d_o,
  input  wire logic                   biu_stb_ack_i,
  input  wire logic                   biu_ack_i,
  input  wire logic                   biu_err_i,
  input  wire logic [`DMEM_XLEN-1:0]  biu_q_i
);

  // Buffer head
  logic                  buf_valid;
  logic                  buf_ready;
  logic [`DMEM_XLEN-1:0] buf_adr;
  biu_size_t             buf_size;
  logic                  buf_we;
  logic [`DMEM_XLEN-1:0] buf_d;
  biu_prot_t             buf_prot;

  // Checker stage
  logic                  chk_valid;
  logic                  chk_ready;
  logic [`DMEM_XLEN-1:0] chk_adr;
  biu_size_t             chk_size;
  logic [3:0]            chk_be;
  logic                  chk_we;
  logic [`DMEM_XLEN-1:0] chk_d;
  biu_prot_t             chk_prot;
  logic                  chk_misaligned;
  logic                  chk_fault;

  ////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////

  dmem_req_buf req_buf0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .st_prv_i    (st_prv_i),
    .mem_req_i   (mem_req_i),
    .mem_adr_i   (mem_adr_i),
    .mem_size_i  (mem_size_i),
    .mem_we_i    (mem_we_i),
    .mem_d_i     (mem_d_i),
    .mem_rdy_o   (mem_rdy_o),
    .buf_valid_o (buf_valid),
    .buf_adr_o   (buf_adr),
    .buf_size_o  (buf_size),
    .buf_we_o    (buf_we),
    .buf_d_o     (buf_d),
    .buf_prot_o  (buf_prot),
    .buf_ready_i (buf_ready)
  );

  // Alignment and PMA check
  dmem_access_chk access_chk0 (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .pma_cfg_i        (pma_cfg_i),
    .pma_adr_i        (pma_adr_i),
    .in_valid_i       (buf_valid),
    .in_adr_i         (buf_adr),
    .in_size_i        (buf_size),
    .in_we_i          (buf_we),
    .in_d_i           (buf_d),
    .in_prot_i        (buf_prot),
    .in_ready_o       (buf_ready),
    .out_valid_o      (chk_valid),
    .out_adr_o        (chk_adr),
    .out_size_o       (chk_size),
    .out_be_o         (chk_be),
    .out_we_o         (chk_we),
    .out_d_o          (chk_d),
    .out_prot_o       (chk_prot),
    .out_misaligned_o (chk_misaligned),
    .out_fault_o      (chk_fault),
    .out_ready_i      (chk_ready)
  );

  ////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////

  dmem_biu_if biu_if0 (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .in_valid_i       (chk_valid),
    .in_adr_i         (chk_adr),
    .in_size_i        (chk_size),
    .in_be_i          (chk_be),
    .in_we_i          (chk_we),
    .in_d_i           (chk_d),
    .in_prot_i        (chk_prot),
    .in_misaligned_i  (chk_misaligned),
    .in_fault_i       (chk_fault),
    .in_ready_o       (chk_ready),
    .biu_stb_o        (biu_stb_o),
    .biu_adr_o        (biu_adr_o),
    .biu_size_o       (biu_size_o),
    .biu_be_o         (biu_be_o),
    .biu_we_o         (biu_we_o),
    .biu_prot_o       (biu_prot_o),
    .biu_d_o          (biu_d_o),
    .biu_stb_ack_i    (biu_stb_ack_i),
    .biu_ack_i        (biu_ack_i),
    .biu_err_i        (biu_err_i),
    .biu_q_i          (biu_q_i),
    .mem_ack_o        (mem_ack_o),
    .mem_err_o        (mem_err_o),
    .mem_misaligned_o (mem_misaligned_o),
    .mem_q_o          (mem_q_o)
  );

endmodule

`default_nettype wire

//--- tb/tb_dmem_ctrl.sv
// Testbench for the data memory access block with bus memory model and reference checker

`timescale 1ns/100ps
`default_nettype none

`include "dmem_defs.svh"

module tb_dmem_ctrl
  import biu_pkg::*;
  import pma_pkg::*;
;

  localparam int TIMEOUT = 1000;
  localparam int N_RAND  = 300;

  // Outcome kinds
  localparam logic [1:0] K_ACK   = 2'd0;
  localparam logic [1:0] K_MISAL = 2'd1;
  localparam logic [1:0] K_FAULT = 2'd2;
  localparam logic [1:0] K_BUSER = 2'd3;

  typedef struct packed {
    logic [1:0]            kind;
    logic                  on_bus;
    biu_prot_t             prot;
    logic [`DMEM_XLEN-1:0] adr;
    biu_size_t             size;
    logic                  we;
    logic [`DMEM_XLEN-1:0] q;
  } expect_t;

  logic                  clk_i;
  logic                  rst_i;
  logic [1:0]            st_prv_i;
  pmacfg_t               pma_cfg [`DMEM_PMA_CNT];
  logic [`DMEM_XLEN-1:0] pma_adr [`DMEM_PMA_CNT];
  logic                  mem_req_i;
  logic [`DMEM_XLEN-1:0] mem_adr_i;
  biu_size_t             mem_size_i;
  logic                  mem_we_i;
  logic [`DMEM_XLEN-1:0] mem_d_i;
  logic                  mem_rdy_o;
  logic                  mem_ack_o;
  logic                  mem_err_o;
  logic                  mem_misaligned_o;
  logic [`DMEM_XLEN-1:0] mem_q_o;
  logic                  biu_stb_o;
  logic [`DMEM_XLEN-1:0] biu_adr_o;
  biu_size_t             biu_size_o;
  logic [3:0]            biu_be_o;
  logic                  biu_we_o;
  biu_prot_t             biu_prot_o;
  logic [`DMEM_XLEN-1:0] biu_d_o;
  logic                  biu_stb_ack_i;
  logic                  biu_ack_i;
  logic                  biu_err_i;
  logic [`DMEM_XLEN-1:0] biu_q_i;

  integer  seed;
  expect_t exp_q [$];
  expect_t bus_q [$];

  // Word-indexed bus model storage and reference shadow
  logic [`DMEM_XLEN-1:0] bus_mem [4096];
  logic [`DMEM_XLEN-1:0] shadow [4096];

  dmem_ctrl dut0 (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .st_prv_i         (st_prv_i),
    .pma_cfg_i        (pma_cfg),
    .pma_adr_i        (pma_adr),
    .mem_req_i        (mem_req_i),
    .mem_adr_i        (mem_adr_i),
    .mem_size_i       (mem_size_i),
    .mem_we_i         (mem_we_i),
    .mem_d_i          (mem_d_i),
    .mem_rdy_o        (mem_rdy_o),
    .mem_ack_o        (mem_ack_o),
    .mem_err_o        (mem_err_o),
    .mem_misaligned_o (mem_misaligned_o),
    .mem_q_o          (mem_q_o),
    .biu_stb_o        (biu_stb_o),
    .biu_adr_o        (biu_adr_o),
    .biu_size_o       (biu_size_o),
    .biu_be_o         (biu_be_o),
    .biu_we_o         (biu_we_o),
    .biu_prot_o       (biu_prot_o),
    .biu_d_o          (biu_d_o),
    .biu_stb_ack_i    (biu_stb_ack_i),
    .biu_ack_i        (biu_ack_i),
    .biu_err_i        (biu_err_i),
    .biu_q_i          (biu_q_i)
  );

  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what);
    stop_run($sformatf("mismatch at %0t: %s", $time, what));
  endtask

  // Initial memory contents unique per word address
  function automatic logic [31:0] fill_word(input int unsigned idx);
    return (idx * 32'h0100_0193) ^ 32'hc0de_0000 ^ idx;
  endfunction

  // Top 256 bytes of region 0 answer with a bus error
  function automatic logic bus_err_adr(input logic [31:0] adr);
    return (adr >= 32'h0000_0f00) && (adr < 32'h0000_1000);
  endfunction

  // Expected outcome from alignment, region and permission rules
  function automatic expect_t predict_outcome(input logic [31:0] adr, input biu_size_t size,
                                              input logic we, input logic [31:0] d,
                                              input logic [1:0] prv);
    expect_t     e;
    logic        hit;
    logic        ok;
    logic        misal;
    logic [31:0] mask;
    logic [31:0] word;
    logic [11:0] idx;
    int          lanes;
    int          lo;
    e                 = '0;
    e.adr             = adr;
    e.size            = size;
    e.we              = we;
    e.prot.data       = 1'b1;
    e.prot.user       = (prv == PRV_U);
    e.prot.privileged = (prv != PRV_U);
    hit   = 1'b0;
    ok    = 1'b0;
    lanes = (size == BYTE) ? 1 : ((size == HWORD) ? 2 : 4);
    lo    = int'(adr[1:0]);
    idx   = adr[13:2];
    misal = ((size == HWORD) && adr[0]) || ((size == WORD) && (adr[1:0] != 2'b00));
    // First matching region decides
    for (int i = 0; i < `DMEM_PMA_CNT; i++)
    begin
      mask = 32'hffff_ffff << pma_cfg[i].size_log2;
      if (!hit && pma_cfg[i].valid && ((adr & mask) == pma_adr[i]))
      begin
        hit = 1'b1;
        ok  = we ? pma_cfg[i].w : pma_cfg[i].r;
      end
    end
    if (misal)
      e.kind = K_MISAL;
    else if (!ok)
      e.kind = K_FAULT;
    else
    begin
      e.on_bus = 1'b1;
      if (bus_err_adr(adr))
        e.kind = K_BUSER;
      else
      begin
        e.kind = K_ACK;
        word   = shadow[idx];
        for (int b = 0; b < lanes; b++)
        begin
          if (we)
            word[8*(lo+b) +: 8] = d[8*b +: 8];
          else
            e.q[8*b +: 8] = word[8*(lo+b) +: 8];
        end
        shadow[idx] = word;
      end
    end
    return e;
  endfunction

  // Hold one request until the buffer takes it
  task automatic issue_request(input logic [31:0] adr, input biu_size_t size, input logic we,
                               input logic [31:0] d, input logic [1:0] prv);
    expect_t e;
    int      cnt;
    mem_req_i  = 1'b1;
    mem_adr_i  = adr;
    mem_size_i = size;
    mem_we_i   = we;
    mem_d_i    = d;
    st_prv_i   = prv;
    cnt        = 0;
    while (!mem_rdy_o)
    begin
      @(posedge clk_i);
      #1;
      cnt++;
      if (cnt >= TIMEOUT)
        stop_run("timeout while waiting for mem_rdy_o");
    end
    e = predict_outcome(adr, size, we, d, prv);
    exp_q.push_back(e);
    if (e.on_bus)
      bus_q.push_back(e);
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle_cycle();
    mem_req_i = 1'b0;
    @(posedge clk_i);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // Bus memory model
  ////////////////////////////////////////////////////////////

  initial
  begin : bus_model
    expect_t     e;
    logic [31:0] adr;
    logic [3:0]  be;
    logic        we;
    logic [31:0] d;
    int          dly;
    @(negedge rst_i);
    forever
    begin
      @(posedge clk_i);
      #1;
      biu_ack_i = 1'b0;
      biu_err_i = 1'b0;
      if (biu_stb_o)
      begin
        assert (bus_q.size() != 0)
        else
          stop_run("bus strobe seen while no request should reach the bus");
        e = bus_q.pop_front();
        // Address, size, direction and protection at the strobe
        assert (biu_adr_o == e.adr && biu_size_o == e.size && biu_we_o == e.we &&
                biu_prot_o == e.prot)
        else
          report_mismatch($sformatf(
            "strobe adr %h size %0d we %b prot %b, expected %h %0d %b %b",
            biu_adr_o, biu_size_o, biu_we_o, biu_prot_o, e.adr, e.size, e.we, e.prot));
        adr = biu_adr_o;
        be  = biu_be_o;
        we  = biu_we_o;
        d   = biu_d_o;
        dly = $random(seed) & 3;
        repeat (dly)
        begin
          @(posedge clk_i);
          #1;
        end
        biu_stb_ack_i = 1'b1;
        @(posedge clk_i);
        #1;
        biu_stb_ack_i = 1'b0;
        dly = $random(seed) & 3;
        repeat (dly)
        begin
          @(posedge clk_i);
          #1;
        end
        if (bus_err_adr(adr))
          biu_err_i = 1'b1;
        else
        begin
          biu_ack_i = 1'b1;
          for (int b = 0; b < 4; b++)
            if (we && be[b])
              bus_mem[adr[13:2]][8*b +: 8] = d[8*b +: 8];
          biu_q_i = bus_mem[adr[13:2]];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response checker
  ////////////////////////////////////////////////////////////

  initial
  begin : compare_responses
    expect_t e;
    forever
    begin
      @(posedge clk_i);
      #1;
      if (!rst_i && (mem_ack_o || mem_err_o))
      begin
        assert (!(mem_ack_o && mem_err_o))
        else
          stop_run("acknowledge and error raised together");
        assert (exp_q.size() != 0)
        else
          stop_run("response seen with no request outstanding");
        e = exp_q.pop_front();
        if (e.kind == K_ACK)
        begin
          assert (mem_ack_o)
          else
            report_mismatch($sformatf("adr %h expected ack, got error", e.adr));
          if (!e.we)
          begin
            assert (mem_q_o == e.q)
            else
              report_mismatch($sformatf("adr %h load data %h, expected %h",
                                        e.adr, mem_q_o, e.q));
          end
        end
        else
        begin
          // Misaligned flag only for the alignment error
          assert (mem_err_o && (mem_misaligned_o == (e.kind == K_MISAL)))
          else
            report_mismatch($sformatf("adr %h ack %b err %b misaligned %b, expected kind %0d",
                                      e.adr, mem_ack_o, mem_err_o, mem_misaligned_o, e.kind));
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial
  begin : stimulus
    logic [31:0] r;
    logic [31:0] sel;
    logic [31:0] adr;
    biu_size_t   size;
    int          cnt;
    seed          = 32'h6ea7e797;
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    st_prv_i      = PRV_M;
    mem_req_i     = 1'b0;
    mem_adr_i     = '0;
    mem_size_i    = WORD;
    mem_we_i      = 1'b0;
    mem_d_i       = '0;
    biu_stb_ack_i = 1'b0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    biu_q_i       = '0;
    // Region table with region 3 sized but invalid
    pma_cfg[0] = '{size_log2: 5'd12, r: 1'b1, w: 1'b1, valid: 1'b1};
    pma_adr[0] = 32'h0000_0000;
    pma_cfg[1] = '{size_log2: 5'd12, r: 1'b1, w: 1'b0, valid: 1'b1};
    pma_adr[1] = 32'h0000_1000;
    pma_cfg[2] = '{size_log2: 5'd8, r: 1'b0, w: 1'b1, valid: 1'b1};
    pma_adr[2] = 32'h0000_2000;
    pma_cfg[3] = '{size_log2: 5'd12, r: 1'b1, w: 1'b1, valid: 1'b0};
    pma_adr[3] = 32'h0000_3000;
    for (int i = 0; i < 4096; i++)
    begin
      bus_mem[i] = fill_word(i);
      shadow[i]  = fill_word(i);
    end
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    assert (mem_rdy_o && !mem_ack_o && !mem_err_o && !biu_stb_o)
    else
      stop_run("outputs not at their reset values after reset");

    // Stores of each size and loads back from region 0
    issue_request(32'h0000_0100, WORD, 1'b1, 32'hdead_beef, PRV_M);
    issue_request(32'h0000_0100, WORD, 1'b0, 32'h0, PRV_M);
    issue_request(32'h0000_0101, BYTE, 1'b0, 32'h0, PRV_M);
    issue_request(32'h0000_0102, HWORD, 1'b0, 32'h0, PRV_U);
    issue_request(32'h0000_0103, BYTE, 1'b1, 32'h0000_00a5, PRV_U);
    issue_request(32'h0000_0106, HWORD, 1'b1, 32'h0000_1234, PRV_M);
    issue_request(32'h0000_0100, WORD, 1'b0, 32'h0, PRV_M);
    issue_request(32'h0000_0104, WORD, 1'b0, 32'h0, PRV_U);
    issue_request(32'h0000_0107, BYTE, 1'b0, 32'h0, PRV_M);
    issue_request(32'h0000_0106, HWORD, 1'b0, 32'h0, PRV_U);
    // Misaligned half and word
    issue_request(32'h0000_0101, HWORD, 1'b0, 32'h0, PRV_M);
    issue_request(32'h0000_0102, WORD, 1'b1, 32'h1111_2222, PRV_M);
    issue_request(32'h0000_0103, WORD, 1'b0, 32'h0, PRV_U);
    // Permission and region faults next to legal accesses
    issue_request(32'h0000_1004, WORD, 1'b1, 32'h5555_aaaa, PRV_M);
    issue_request(32'h0000_1004, WORD, 1'b0, 32'h0, PRV_U);
    issue_request(32'h0000_2010, WORD, 1'b0, 32'h0, PRV_M);
    issue_request(32'h0000_2010, WORD, 1'b1, 32'h0bad_cafe, PRV_U);
    issue_request(32'h0000_2100, BYTE, 1'b1, 32'h0000_0077, PRV_M);
    issue_request(32'h0000_3004, WORD, 1'b0, 32'h0, PRV_M);
    issue_request(32'h8000_0000, WORD, 1'b0, 32'h0, PRV_U);
    // Bus errors then normal traffic again
    issue_request(32'h0000_0f40, WORD, 1'b0, 32'h0, PRV_M);
    issue_request(32'h0000_0ffc, BYTE, 1'b1, 32'h0000_0042, PRV_U);
    issue_request(32'h0000_0100, WORD, 1'b0, 32'h0, PRV_M);
    idle_cycle();

    // Random traffic mostly aligned with idle gaps
    for (int n = 0; n < N_RAND; n++)
    begin
      r   = $random(seed);
      sel = $random(seed);
      case (sel[1:0])
        2'd0:    adr = {20'h0, r[11:0]};
        2'd1:    adr = 32'h0000_1000 | {20'h0, r[11:0]};
        2'd2:    adr = 32'h0000_2000 | {23'h0, r[8:0]};
        default: adr = r;
      endcase
      case (sel[3:2])
        2'd0:    size = BYTE;
        2'd1:    size = HWORD;
        default: size = WORD;
      endcase
      if (sel[6:4] != 3'd0)
        adr = (size == WORD) ? {adr[31:2], 2'b00} : ((size == HWORD) ? {adr[31:1], 1'b0} : adr);
      issue_request(adr, size, sel[7], $random(seed), sel[8] ? PRV_U : PRV_M);
      if (sel[11:9] == 3'd0)
        idle_cycle();
    end
    idle_cycle();

    // Drain everything in flight
    cnt = 0;
    while (exp_q.size() != 0 && cnt < TIMEOUT)
    begin
      @(posedge clk_i);
      #1;
      cnt++;
    end
    if (exp_q.size() == 0 && bus_q.size() == 0)
    begin
      $display("TEST PASS");
      $finish;
    end
    else
    begin
      stop_run("timeout while waiting for outstanding responses");
    end
  end

endmodule

`default_nettype wire

//--- dmem_access.f
+incdir+hw
hw/biu_pkg.sv
hw/pma_pkg.sv
hw/dmem_req_buf.sv
hw/dmem_access_chk.sv
hw/dmem_biu_if.sv
hw/dmem_ctrl.sv
tb/tb_dmem_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0 -Wno-fatal
TOP       := tb_dmem_ctrl
FILELIST  := dmem_access.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

SRCS := $(wildcard hw/*.sv hw/*.svh tb/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
